// File: pkt_triple_buf.f
logic/pkt_pkg.sv
logic/snooper.sv
logic/buf_ctrl.sv
logic/muxes.sv
logic/pkt_buf.sv
logic/forwarder.sv
logic/pkt_triple_buf.sv
tb/pkt_triple_buf_sva.sv
tb/tb_pkt_triple_buf.sv

// File: Makefile
TOP := tb_pkt_triple_buf

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f pkt_triple_buf.f

# Assertion errors must not stop the run before the testbench reports
run: build
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee /dev/stderr | grep -F '** PASS **' > /dev/null

lint:
	verilator --lint-only -Wall --timing --top-module pkt_triple_buf -f pkt_triple_buf.f

clean:
	rm -rf obj_dir

// File: tb/tb_pkt_triple_buf.sv
`timescale 1ns/1ps

module tb_pkt_triple_buf import pkt_pkg::*; ();

	localparam int ADDR_W = ADDR_W_DEF;
	localparam int DATA_W = DATA_W_DEF;
	localparam int PLEN_W = PLEN_W_DEF;
	// Longest any single wait may run in cycles
	localparam int WAIT_LIMIT = 4000;
	// Longest in_ready low spell after a packet when both consumers are idle
	localparam int ROTATE_CYCLES = 4;

	logic              clk = 1'b0;
	logic              rst_n;
	logic              in_valid;
	logic [DATA_W-1:0] in_data;
	logic [3:0]        in_bytes;
	logic              in_last;
	logic [ADDR_W-1:0] cpu_addr = '0;
	logic              cpu_rd_en = 1'b0;
	logic              cpu_done = 1'b0;
	logic              cpu_drop = 1'b0;
	logic              in_ready;
	logic              cpu_start;
	logic [DATA_W-1:0] cpu_rd_data;
	logic [PLEN_W-1:0] cpu_len;
	logic              out_valid;
	logic [DATA_W-1:0] out_data;
	logic [3:0]        out_bytes;
	logic              out_last;

	// Expected output stream of kept packets only
	logic [DATA_W-1:0] exp_data [$];
	logic [3:0]        exp_bytes [$];
	logic              exp_last [$];
	// Every packet sent in order as the CPU should see it
	logic [DATA_W-1:0] cpu_words [$];
	int                cpu_nwords [$];
	int                cpu_lens [$];

	string test_name = "none";
	int    errors = 0;
	int    checks = 0;
	int    tests_run = 0;
	int    tests_failed = 0;
	int    test_err0 = 0;
	int    pkts_sent = 0;
	int    cpu_seen = 0;
	int    cpu_delay = 0;
	int    gap_max = 3;
	logic  low_seen = 1'b0;

	// History for the protocol monitor
	logic       prev_cpu_start = 1'b0;
	logic       prev_out_valid = 1'b0;
	logic       fs_h1 = 1'b0;
	logic       fs_h2 = 1'b0;
	logic [1:0] sel_ping, sel_pang, sel_pong;

	pkt_triple_buf #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .INC_W(INC_W_DEF), .PLEN_W(PLEN_W))
	u_pkt_triple_buf (
		.clk, .rst_n, .in_valid, .in_data, .in_bytes, .in_last,
		.cpu_addr, .cpu_rd_en, .cpu_done, .cpu_drop,
		.in_ready, .cpu_start, .cpu_rd_data, .cpu_len,
		.out_valid, .out_data, .out_bytes, .out_last
	);

	always #4 clk = ~clk;

	assign sel_ping = u_pkt_triple_buf.ping_sel;
	assign sel_pang = u_pkt_triple_buf.pang_sel;
	assign sel_pong = u_pkt_triple_buf.pong_sel;

	task automatic timeout_abort(input string what);
		errors++;
		$display("%s: gave up waiting for %s after %0d cycles",
			test_name, what, WAIT_LIMIT);
		$display("** FAIL **");
		$finish;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_err0 = errors;
		tests_run++;
	endtask

	task automatic finish_test();
		if (errors != test_err0) begin
			tests_failed++;
			$display("test %s: failed, %0d errors", test_name, errors - test_err0);
		end else begin
			$display("test %s: passed", test_name);
		end
	endtask

	// Present one word and hold it until the DUT can take it
	task automatic offer_word(input logic [DATA_W-1:0] d, input logic [3:0] nb,
		input logic last);
		int t;
		in_valid = 1'b1;
		in_data  = d;
		in_bytes = nb;
		in_last  = last;
		t = 0;
		while (!in_ready && t < WAIT_LIMIT) begin
			@(negedge clk);
			t++;
		end
		if (t >= WAIT_LIMIT) begin
			timeout_abort("in_ready");
		end else begin
			// Held off longer than a rotation with idle consumers takes
			if (t > ROTATE_CYCLES)
				low_seen = 1'b1;
			// Taken at the rising edge in between
			@(negedge clk);
			in_valid = 1'b0;
			in_last  = 1'b0;
		end
	endtask

	// Bit 0 of the first word carries the drop verdict
	task automatic send_packet(input int n_words, input logic drop);
		logic [DATA_W-1:0] w [$];
		logic [DATA_W-1:0] word;
		logic [3:0]        nb;
		int                gap;
		nb = 4'($urandom_range(8, 1));
		for (int i = 0; i < n_words; i++) begin
			word = {$urandom(), $urandom()};
			if (i == 0)
				word[0] = drop;
			w.push_back(word);
			cpu_words.push_back(word);
			if (!drop) begin
				exp_data.push_back(word);
				exp_bytes.push_back((i == n_words - 1) ? nb : 4'd8);
				exp_last.push_back(i == n_words - 1);
			end
		end
		// Length in bytes is full words plus the short tail
		cpu_lens.push_back(8 * (n_words - 1) + int'(nb));
		cpu_nwords.push_back(n_words);
		pkts_sent++;
		for (int i = 0; i < n_words; i++) begin
			offer_word(w[i], (i == n_words - 1) ? nb : 4'd8, i == n_words - 1);
			gap = $urandom_range(gap_max, 0);
			repeat (gap) @(negedge clk);
		end
	endtask

	// A dropped one-word packet pushes the previous packet to the forwarder
	task automatic flush_and_drain();
		int t;
		send_packet(1, 1'b1);
		t = 0;
		while ((exp_data.size() != 0 || cpu_seen != pkts_sent || out_valid)
			&& t < WAIT_LIMIT) begin
			@(negedge clk);
			t++;
		end
		if (t >= WAIT_LIMIT)
			timeout_abort("the output stream to drain");
	endtask

	// CPU model reads length and every word before its verdict
	task automatic serve_cpu();
		logic [DATA_W-1:0] w;
		logic              first_bit;
		int                n;
		int                len;
		if (cpu_nwords.size() == 0) begin
			$display("%s: cpu_start with no packet outstanding", test_name);
			errors++;
		end else begin
			n = cpu_nwords.pop_front();
			len = cpu_lens.pop_front();
			first_bit = 1'b0;
			checks++;
			assert (cpu_len == PLEN_W'(len)) else begin
				$display("[ERROR] %s: cpu_len expected %0d actual %0d",
					test_name, len, cpu_len);
				errors++;
			end
			for (int i = 0; i < n; i++) begin
				w = cpu_words.pop_front();
				if (i == 0)
					first_bit = w[0];
				cpu_addr  = ADDR_W'(i);
				cpu_rd_en = 1'b1;
				@(negedge clk);
				checks++;
				assert (cpu_rd_data == w) else begin
					$display("[ERROR] %s: cpu_rd_data[%0d] expected %h actual %h",
						test_name, i, w, cpu_rd_data);
					errors++;
				end
			end
			cpu_rd_en = 1'b0;
			cpu_addr  = '0;
			// Slow CPU holds its buffer a while
			repeat (cpu_delay) @(negedge clk);
			cpu_done = 1'b1;
			cpu_drop = first_bit;
			@(negedge clk);
			cpu_done = 1'b0;
			cpu_drop = 1'b0;
			cpu_seen++;
		end
	endtask

	always @(negedge clk)
		if (rst_n && cpu_start)
			serve_cpu();

	// Output stream checked in order against the kept packets
	always @(negedge clk) begin : out_check
		logic [DATA_W-1:0] ed;
		logic [3:0]        eb;
		logic              el;
		if (rst_n && out_valid) begin
			if (exp_data.size() == 0) begin
				$display("%s: output word %h with no kept packet pending",
					test_name, out_data);
				errors++;
			end else begin
				ed = exp_data.pop_front();
				eb = exp_bytes.pop_front();
				el = exp_last.pop_front();
				checks += 3;
				assert (out_data == ed) else begin
					$display("[ERROR] %s: out_data expected %h actual %h",
						test_name, ed, out_data);
					errors++;
				end
				assert (out_bytes == eb) else begin
					$display("[ERROR] %s: out_bytes expected %0d actual %0d",
						test_name, eb, out_bytes);
					errors++;
				end
				assert (out_last == el) else begin
					$display("[ERROR] %s: out_last expected %b actual %b",
						test_name, el, out_last);
					errors++;
				end
			end
		end
	end

	// Same ownership and protocol rules as the bound checker
	always @(negedge clk) begin
		if (rst_n) begin
			assert (sel_ping != 2'd0 && sel_pang != 2'd0 && sel_pong != 2'd0
				&& sel_ping != sel_pang && sel_ping != sel_pong
				&& sel_pang != sel_pong) else begin
				$display("%s: a buffer is shared or has no owner", test_name);
				errors++;
			end
			assert (!(u_pkt_triple_buf.u_buf_ctrl.state == CTRL_WAIT && in_ready)) else begin
				$display("%s: in_ready stayed high while the controller waited", test_name);
				errors++;
			end
			assert (!(prev_cpu_start && cpu_start)) else begin
				$display("%s: cpu_start lasted more than one cycle", test_name);
				errors++;
			end
			assert (!(out_valid && !prev_out_valid && !fs_h2)) else begin
				$display("%s: out_valid rose without fwd_start two cycles before", test_name);
				errors++;
			end
		end
		prev_cpu_start = cpu_start;
		prev_out_valid = out_valid;
		fs_h2 = fs_h1;
		fs_h1 = u_pkt_triple_buf.fwd_start;
	end

	initial begin
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in_data  = '0;
		in_bytes = '0;
		in_last  = 1'b0;
		void'($urandom(32'he588));
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		start_test("reset_state");
		checks += 3;
		assert (in_ready === 1'b1) else begin
			$display("[ERROR] %s: in_ready expected 1 actual %b", test_name, in_ready);
			errors++;
		end
		assert (out_valid === 1'b0) else begin
			$display("[ERROR] %s: out_valid expected 0 actual %b", test_name, out_valid);
			errors++;
		end
		assert (cpu_start === 1'b0) else begin
			$display("[ERROR] %s: cpu_start expected 0 actual %b", test_name, cpu_start);
			errors++;
		end
		finish_test();

		start_test("single_kept");
		send_packet($urandom_range(40, 1), 1'b0);
		flush_and_drain();
		finish_test();

		start_test("cpu_view");
		repeat (3) send_packet($urandom_range(40, 1), 1'b0);
		flush_and_drain();
		finish_test();

		// Dropped packet sits between two kept ones
		start_test("drop_rule");
		send_packet($urandom_range(40, 1), 1'b0);
		send_packet($urandom_range(40, 1), 1'b1);
		send_packet($urandom_range(40, 1), 1'b0);
		flush_and_drain();
		finish_test();

		start_test("back_pressure");
		gap_max = 0;
		cpu_delay = 40;
		low_seen = 1'b0;
		repeat (10) send_packet($urandom_range(40, 1), 1'($urandom_range(1, 0)));
		flush_and_drain();
		assert (low_seen) else begin
			$display("%s: in_ready never held a word back on a busy consumer", test_name);
			errors++;
		end
		finish_test();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: tb/pkt_triple_buf_sva.sv
`timescale 1ns/1ps

module pkt_triple_buf_sva import pkt_pkg::*; (
	input logic        clk,
	input logic        rst_n,
	input logic        in_ready,
	input logic        cpu_start,
	input logic        fwd_start,
	input logic        out_valid,
	input ctrl_state_e state,
	input agent_sel_e  ping_sel,
	input agent_sel_e  pang_sel,
	input agent_sel_e  pong_sel
);

	// Every buffer held by a distinct agent
	a_owners_distinct: assert property (@(posedge clk) disable iff (!rst_n)
		(ping_sel != AGT_NONE) && (pang_sel != AGT_NONE) && (pong_sel != AGT_NONE)
		&& (ping_sel != pang_sel) && (ping_sel != pong_sel) && (pang_sel != pong_sel))
		else $error("buffer ownership is not one agent per buffer");

	// Input path closed while the controller waits on its consumers
	a_wait_closed: assert property (@(posedge clk) disable iff (!rst_n)
		(state == CTRL_WAIT) |-> !in_ready)
		else $error("in_ready high while the controller waits");

	// One pulse per rotation
	a_cpu_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_start |=> !cpu_start)
		else $error("cpu_start held for more than one cycle");

	// Output stream opens two cycles after the forwarder is started
	a_out_after_start: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(out_valid) |-> $past(fwd_start, 2))
		else $error("out_valid rose without a preceding fwd_start");

endmodule

bind pkt_triple_buf pkt_triple_buf_sva u_sva (
	.clk,
	.rst_n,
	.in_ready,
	.cpu_start,
	.fwd_start,
	.out_valid,
	.state(u_buf_ctrl.state),
	.ping_sel,
	.pang_sel,
	.pong_sel
);

// File: logic/pkt_triple_buf.sv
`timescale 1ns/1ps

module pkt_triple_buf import pkt_pkg::*; #(
	parameter int ADDR_W = ADDR_W_DEF,
	parameter int DATA_W = DATA_W_DEF,
	parameter int INC_W  = INC_W_DEF,
	parameter int PLEN_W = PLEN_W_DEF
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  logic [DATA_W-1:0] in_data,
	input  logic [3:0]        in_bytes,
	input  logic              in_last,
	input  logic [ADDR_W-1:0] cpu_addr,
	input  logic              cpu_rd_en,
	input  logic              cpu_done,
	input  logic              cpu_drop,
	output logic              in_ready,
	output logic              cpu_start,
	output logic [DATA_W-1:0] cpu_rd_data,
	output logic [PLEN_W-1:0] cpu_len,
	output logic              out_valid,
	output logic [DATA_W-1:0] out_data,
	output logic [3:0]        out_bytes,
	output logic              out_last
);

	logic [ADDR_W-1:0] sn_addr, fwd_addr;
	logic [DATA_W-1:0] sn_wr_data, fwd_rd_data;
	logic              sn_wr_en, sn_done, fwd_rd_en, fwd_start, fwd_done;
	logic [INC_W-1:0]  sn_inc;
	logic [PLEN_W-1:0] fwd_len;
	logic [2:0]        buf_clr;
	logic              ctrl_ready;
	// Last word taken but sn_done not yet seen by the controller
	logic              closing;
	buf_sel_e          sn_sel, cpu_sel, fwd_sel;
	agent_sel_e        ping_sel, pang_sel, pong_sel;

	// Buffer ports, index 0 ping, 1 pang, 2 pong
	logic [ADDR_W-1:0] b_addr [3];
	logic [DATA_W-1:0] b_wr_data [3];
	logic [DATA_W-1:0] b_rd_data [3];
	logic              b_wr_en [3];
	logic              b_rd_en [3];
	logic [INC_W-1:0]  b_inc [3];
	logic [PLEN_W-1:0] b_len [3];

	// Close the input between the last word and the controller's WAIT state
	always_ff @(posedge clk) begin
		if (!rst_n)
			closing <= 1'b0;
		else if (in_valid && in_ready && in_last)
			closing <= 1'b1;
		else if (sn_done)
			closing <= 1'b0;
	end

	assign in_ready = ctrl_ready && !closing;

	snooper #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .INC_W(INC_W)) u_snooper (
		.clk, .rst_n, .in_valid, .in_data, .in_bytes, .in_last, .in_ready,
		.sn_addr, .sn_wr_data, .sn_wr_en, .sn_inc, .sn_done
	);

	buf_ctrl u_buf_ctrl (
		.clk, .rst_n, .sn_done, .cpu_done, .cpu_drop, .fwd_done,
		.in_ready(ctrl_ready), .cpu_start, .fwd_start, .buf_clr,
		.sn_sel, .cpu_sel, .fwd_sel, .ping_sel, .pang_sel, .pong_sel
	);

	muxes #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .INC_W(INC_W), .PLEN_W(PLEN_W)) u_muxes (
		.sn_addr, .sn_wr_data, .sn_wr_en, .sn_inc,
		.cpu_addr, .cpu_rd_en, .fwd_addr, .fwd_rd_en,
		.ping_rd_data(b_rd_data[0]), .ping_len(b_len[0]),
		.pang_rd_data(b_rd_data[1]), .pang_len(b_len[1]),
		.pong_rd_data(b_rd_data[2]), .pong_len(b_len[2]),
		.sn_sel, .cpu_sel, .fwd_sel, .ping_sel, .pang_sel, .pong_sel,
		.ping_addr(b_addr[0]), .ping_wr_data(b_wr_data[0]), .ping_wr_en(b_wr_en[0]),
		.ping_inc(b_inc[0]), .ping_rd_en(b_rd_en[0]),
		.pang_addr(b_addr[1]), .pang_wr_data(b_wr_data[1]), .pang_wr_en(b_wr_en[1]),
		.pang_inc(b_inc[1]), .pang_rd_en(b_rd_en[1]),
		.pong_addr(b_addr[2]), .pong_wr_data(b_wr_data[2]), .pong_wr_en(b_wr_en[2]),
		.pong_inc(b_inc[2]), .pong_rd_en(b_rd_en[2]),
		.cpu_rd_data, .cpu_len, .fwd_rd_data, .fwd_len
	);

	pkt_buf #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .INC_W(INC_W), .PLEN_W(PLEN_W)) u_ping (
		.clk, .rst_n, .clr(buf_clr[0]), .addr(b_addr[0]), .wr_data(b_wr_data[0]),
		.wr_en(b_wr_en[0]), .inc(b_inc[0]), .rd_en(b_rd_en[0]),
		.rd_data(b_rd_data[0]), .len(b_len[0])
	);

	pkt_buf #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .INC_W(INC_W), .PLEN_W(PLEN_W)) u_pang (
		.clk, .rst_n, .clr(buf_clr[1]), .addr(b_addr[1]), .wr_data(b_wr_data[1]),
		.wr_en(b_wr_en[1]), .inc(b_inc[1]), .rd_en(b_rd_en[1]),
		.rd_data(b_rd_data[1]), .len(b_len[1])
	);

	pkt_buf #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .INC_W(INC_W), .PLEN_W(PLEN_W)) u_pong (
		.clk, .rst_n, .clr(buf_clr[2]), .addr(b_addr[2]), .wr_data(b_wr_data[2]),
		.wr_en(b_wr_en[2]), .inc(b_inc[2]), .rd_en(b_rd_en[2]),
		.rd_data(b_rd_data[2]), .len(b_len[2])
	);

	forwarder #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .PLEN_W(PLEN_W)) u_forwarder (
		.clk, .rst_n, .fwd_start, .fwd_rd_data, .fwd_len, .fwd_addr, .fwd_rd_en,
		.out_valid, .out_data, .out_bytes, .out_last, .fwd_done
	);

endmodule

// File: logic/forwarder.sv
`timescale 1ns/1ps

module forwarder import pkt_pkg::*; #(
	parameter int ADDR_W = ADDR_W_DEF,
	parameter int DATA_W = DATA_W_DEF,
	parameter int PLEN_W = PLEN_W_DEF
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              fwd_start,
	input  logic [DATA_W-1:0] fwd_rd_data,
	input  logic [PLEN_W-1:0] fwd_len,
	output logic [ADDR_W-1:0] fwd_addr,
	output logic              fwd_rd_en,
	output logic              out_valid,
	output logic [DATA_W-1:0] out_data,
	output logic [3:0]        out_bytes,
	output logic              out_last,
	output logic              fwd_done
);

	// One extra bit so a full buffer count fits
	localparam int CNT_W = ADDR_W + 1;

	logic              busy;
	logic [CNT_W-1:0]  n_words;
	logic [CNT_W-1:0]  rd_cnt;
	logic [3:0]        last_bytes;
	// Read issued last cycle, and whether it was the final one
	logic              rd_vld;
	logic              rd_last;
	logic [CNT_W-1:0]  words_now;
	logic [CNT_W-1:0]  cur_words;
	logic [CNT_W-1:0]  cur_idx;
	logic              issue_last;

	// Ceiling of length over eight bytes
	assign words_now  = CNT_W'((fwd_len + PLEN_W'(7)) >> 3);
	// First read goes out in the start cycle itself
	assign cur_words  = fwd_start ? words_now : n_words;
	assign cur_idx    = fwd_start ? '0 : rd_cnt;
	assign issue_last = (cur_idx == cur_words - 1'b1);
	assign fwd_rd_en  = fwd_start || busy;
	assign fwd_addr   = cur_idx[ADDR_W-1:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			rd_cnt    <= '0;
			rd_vld    <= 1'b0;
			rd_last   <= 1'b0;
			out_valid <= 1'b0;
			out_last  <= 1'b0;
			fwd_done  <= 1'b0;
		end else begin
			// Addresses run ahead, data trails by the buffer read stage
			rd_vld    <= fwd_rd_en;
			rd_last   <= fwd_rd_en && issue_last;
			out_valid <= rd_vld;
			out_last  <= rd_vld && rd_last;
			fwd_done  <= out_valid && out_last;
			if (fwd_rd_en) begin
				rd_cnt <= cur_idx + 1'b1;
				busy   <= !issue_last;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fwd_start) begin
			n_words    <= words_now;
			// Remainder bytes, a whole word when it divides evenly
			last_bytes <= (fwd_len[2:0] == 3'd0) ? 4'd8 : {1'b0, fwd_len[2:0]};
		end
		out_data  <= fwd_rd_data;
		out_bytes <= rd_last ? last_bytes : 4'd8;
	end

endmodule

// File: logic/pkt_buf.sv
`timescale 1ns/1ps

module pkt_buf import pkt_pkg::*; #(
	parameter int ADDR_W = ADDR_W_DEF,
	parameter int DATA_W = DATA_W_DEF,
	parameter int INC_W  = INC_W_DEF,
	parameter int PLEN_W = PLEN_W_DEF
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              clr,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] wr_data,
	input  logic              wr_en,
	input  logic [INC_W-1:0]  inc,
	input  logic              rd_en,
	output logic [DATA_W-1:0] rd_data,
	output logic [PLEN_W-1:0] len
);

	// One packet worth of words
	logic [DATA_W-1:0] mem [2**ADDR_W];

	// Single port, a write and a read never share a cycle
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[addr] <= wr_data;
		// Registered read, data one cycle after rd_en
		if (rd_en)
			rd_data <= mem[addr];
	end

	// Length accumulates in bytes with every write
	always_ff @(posedge clk) begin
		if (!rst_n)
			len <= '0;
		else if (clr)
			len <= '0;
		else if (wr_en)
			len <= len + PLEN_W'(inc);
	end

endmodule

// File: logic/muxes.sv
`timescale 1ns/1ps

module muxes import pkt_pkg::*; #(
	parameter int ADDR_W = ADDR_W_DEF,
	parameter int DATA_W = DATA_W_DEF,
	parameter int INC_W  = INC_W_DEF,
	parameter int PLEN_W = PLEN_W_DEF
) (
	// Agent side
	input  logic [ADDR_W-1:0] sn_addr,
	input  logic [DATA_W-1:0] sn_wr_data,
	input  logic              sn_wr_en,
	input  logic [INC_W-1:0]  sn_inc,
	input  logic [ADDR_W-1:0] cpu_addr,
	input  logic              cpu_rd_en,
	input  logic [ADDR_W-1:0] fwd_addr,
	input  logic              fwd_rd_en,
	// Buffer side returns
	input  logic [DATA_W-1:0] ping_rd_data,
	input  logic [PLEN_W-1:0] ping_len,
	input  logic [DATA_W-1:0] pang_rd_data,
	input  logic [PLEN_W-1:0] pang_len,
	input  logic [DATA_W-1:0] pong_rd_data,
	input  logic [PLEN_W-1:0] pong_len,
	// Selects
	input  buf_sel_e          sn_sel,
	input  buf_sel_e          cpu_sel,
	input  buf_sel_e          fwd_sel,
	input  agent_sel_e        ping_sel,
	input  agent_sel_e        pang_sel,
	input  agent_sel_e        pong_sel,
	// To the buffers
	output logic [ADDR_W-1:0] ping_addr,
	output logic [DATA_W-1:0] ping_wr_data,
	output logic              ping_wr_en,
	output logic [INC_W-1:0]  ping_inc,
	output logic              ping_rd_en,
	output logic [ADDR_W-1:0] pang_addr,
	output logic [DATA_W-1:0] pang_wr_data,
	output logic              pang_wr_en,
	output logic [INC_W-1:0]  pang_inc,
	output logic              pang_rd_en,
	output logic [ADDR_W-1:0] pong_addr,
	output logic [DATA_W-1:0] pong_wr_data,
	output logic              pong_wr_en,
	output logic [INC_W-1:0]  pong_inc,
	output logic              pong_rd_en,
	// Back to the readers
	output logic [DATA_W-1:0] cpu_rd_data,
	output logic [PLEN_W-1:0] cpu_len,
	output logic [DATA_W-1:0] fwd_rd_data,
	output logic [PLEN_W-1:0] fwd_len
);

	// Readers pick one buffer, nothing selected gives zeros
	assign cpu_rd_data = (cpu_sel == BUF_PING) ? ping_rd_data :
		(cpu_sel == BUF_PANG) ? pang_rd_data :
		(cpu_sel == BUF_PONG) ? pong_rd_data : '0;
	assign cpu_len = (cpu_sel == BUF_PING) ? ping_len :
		(cpu_sel == BUF_PANG) ? pang_len :
		(cpu_sel == BUF_PONG) ? pong_len : '0;
	assign fwd_rd_data = (fwd_sel == BUF_PING) ? ping_rd_data :
		(fwd_sel == BUF_PANG) ? pang_rd_data :
		(fwd_sel == BUF_PONG) ? pong_rd_data : '0;
	assign fwd_len = (fwd_sel == BUF_PING) ? ping_len :
		(fwd_sel == BUF_PANG) ? pang_len :
		(fwd_sel == BUF_PONG) ? pong_len : '0;

	// Write fields only come from the snooper, read enable only from readers
	// Writes also need the snooper side to point at the same buffer
	assign ping_addr = (ping_sel == AGT_SN) ? sn_addr :
		(ping_sel == AGT_CPU) ? cpu_addr :
		(ping_sel == AGT_FWD) ? fwd_addr : '0;
	assign ping_wr_data = (ping_sel == AGT_SN) ? sn_wr_data : '0;
	assign ping_wr_en   = (ping_sel == AGT_SN) && (sn_sel == BUF_PING) && sn_wr_en;
	assign ping_inc     = (ping_sel == AGT_SN) ? sn_inc : '0;
	assign ping_rd_en   = (ping_sel == AGT_CPU) ? cpu_rd_en :
		(ping_sel == AGT_FWD) ? fwd_rd_en : 1'b0;

	assign pang_addr = (pang_sel == AGT_SN) ? sn_addr :
		(pang_sel == AGT_CPU) ? cpu_addr :
		(pang_sel == AGT_FWD) ? fwd_addr : '0;
	assign pang_wr_data = (pang_sel == AGT_SN) ? sn_wr_data : '0;
	assign pang_wr_en   = (pang_sel == AGT_SN) && (sn_sel == BUF_PANG) && sn_wr_en;
	assign pang_inc     = (pang_sel == AGT_SN) ? sn_inc : '0;
	assign pang_rd_en   = (pang_sel == AGT_CPU) ? cpu_rd_en :
		(pang_sel == AGT_FWD) ? fwd_rd_en : 1'b0;

	assign pong_addr = (pong_sel == AGT_SN) ? sn_addr :
		(pong_sel == AGT_CPU) ? cpu_addr :
		(pong_sel == AGT_FWD) ? fwd_addr : '0;
	assign pong_wr_data = (pong_sel == AGT_SN) ? sn_wr_data : '0;
	assign pong_wr_en   = (pong_sel == AGT_SN) && (sn_sel == BUF_PONG) && sn_wr_en;
	assign pong_inc     = (pong_sel == AGT_SN) ? sn_inc : '0;
	assign pong_rd_en   = (pong_sel == AGT_CPU) ? cpu_rd_en :
		(pong_sel == AGT_FWD) ? fwd_rd_en : 1'b0;

endmodule

// File: logic/buf_ctrl.sv
`timescale 1ns/1ps

module buf_ctrl import pkt_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       sn_done,
	input  logic       cpu_done,
	input  logic       cpu_drop,
	input  logic       fwd_done,
	output logic       in_ready,
	output logic       cpu_start,
	output logic       fwd_start,
	output logic [2:0] buf_clr,
	output buf_sel_e   sn_sel,
	output buf_sel_e   cpu_sel,
	output buf_sel_e   fwd_sel,
	output agent_sel_e ping_sel,
	output agent_sel_e pang_sel,
	output agent_sel_e pong_sel
);

	ctrl_state_e state;
	// Keep verdict per buffer, bit 0 ping, bit 1 pang, bit 2 pong
	logic [2:0]  keep;
	logic        cpu_idle;
	logic        fwd_idle;
	// Verdict of the packet about to move to the forwarder
	logic        fwd_kept;

	function automatic logic [2:0] buf_onehot(input buf_sel_e b);
		case (b)
			BUF_PING: return 3'b001;
			BUF_PANG: return 3'b010;
			BUF_PONG: return 3'b100;
			default:  return 3'b000;
		endcase
	endfunction

	// Reverse lookup of the ownership record
	function automatic agent_sel_e owner_of(input buf_sel_e b, input buf_sel_e s,
		input buf_sel_e c, input buf_sel_e f);
		if (s == b)
			return AGT_SN;
		if (c == b)
			return AGT_CPU;
		if (f == b)
			return AGT_FWD;
		return AGT_NONE;
	endfunction

	assign fwd_kept = |(keep & buf_onehot(cpu_sel));
	assign in_ready = (state == CTRL_FILL);
	// The forwarder's old buffer is wiped as it passes to the snooper
	assign buf_clr  = (state == CTRL_ROTATE) ? buf_onehot(fwd_sel) : 3'b000;

	// Buffer side follows from the same record
	assign ping_sel = owner_of(BUF_PING, sn_sel, cpu_sel, fwd_sel);
	assign pang_sel = owner_of(BUF_PANG, sn_sel, cpu_sel, fwd_sel);
	assign pong_sel = owner_of(BUF_PONG, sn_sel, cpu_sel, fwd_sel);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= CTRL_FILL;
			sn_sel    <= BUF_PING;
			cpu_sel   <= BUF_PANG;
			fwd_sel   <= BUF_PONG;
			cpu_start <= 1'b0;
			fwd_start <= 1'b0;
		end else begin
			cpu_start <= 1'b0;
			fwd_start <= 1'b0;
			case (state)
				CTRL_FILL:
					if (sn_done)
						state <= CTRL_WAIT;
				// Hold the full buffer until both consumers let go
				CTRL_WAIT:
					if (cpu_idle && fwd_idle)
						state <= CTRL_ROTATE;
				CTRL_ROTATE: begin
					// Snooper to CPU, CPU to forwarder, forwarder to snooper
					sn_sel    <= fwd_sel;
					cpu_sel   <= sn_sel;
					fwd_sel   <= cpu_sel;
					cpu_start <= 1'b1;
					fwd_start <= fwd_kept;
					state     <= CTRL_FILL;
				end
				default: state <= CTRL_FILL;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cpu_idle <= 1'b1;
			fwd_idle <= 1'b1;
			keep     <= 3'b000;
		end else begin
			if (cpu_start)
				cpu_idle <= 1'b0;
			else if (cpu_done)
				cpu_idle <= 1'b1;
			// A dropped packet leaves the forwarder idle
			if (fwd_start)
				fwd_idle <= 1'b0;
			else if (fwd_done || (state == CTRL_ROTATE && !fwd_kept))
				fwd_idle <= 1'b1;
			if (cpu_done)
				keep <= cpu_drop ? (keep & ~buf_onehot(cpu_sel)) : (keep | buf_onehot(cpu_sel));
		end
	end

endmodule

// File: logic/snooper.sv
`timescale 1ns/1ps

module snooper import pkt_pkg::*; #(
	parameter int ADDR_W = ADDR_W_DEF,
	parameter int DATA_W = DATA_W_DEF,
	parameter int INC_W  = INC_W_DEF
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  logic [DATA_W-1:0] in_data,
	input  logic [3:0]        in_bytes,
	input  logic              in_last,
	input  logic              in_ready,
	output logic [ADDR_W-1:0] sn_addr,
	output logic [DATA_W-1:0] sn_wr_data,
	output logic              sn_wr_en,
	output logic [INC_W-1:0]  sn_inc,
	output logic              sn_done
);

	// Word position inside the current packet
	logic [ADDR_W-1:0] wr_cnt;
	// Registered write is the final word of its packet
	logic              wr_last;
	logic              accept;

	// A word only counts while the path is open
	assign accept = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_cnt   <= '0;
			sn_wr_en <= 1'b0;
			wr_last  <= 1'b0;
			sn_done  <= 1'b0;
		end else begin
			sn_wr_en <= accept;
			wr_last  <= accept && in_last;
			// Done one cycle behind the last write
			sn_done  <= sn_wr_en && wr_last;
			// Rewind for the next packet after the last word
			if (accept)
				wr_cnt <= in_last ? '0 : wr_cnt + 1'b1;
		end
	end

	// Payload of the write, qualified by sn_wr_en downstream
	always_ff @(posedge clk) begin
		if (accept) begin
			sn_addr    <= wr_cnt;
			sn_wr_data <= in_data;
			// Byte count of the word grows the packet length
			sn_inc     <= INC_W'(in_bytes);
		end
	end

endmodule

// File: logic/pkt_pkg.sv
package pkt_pkg;

	// Word address width inside one buffer
	localparam int ADDR_W_DEF = 6;
	// Payload word width, eight bytes per word
	localparam int DATA_W_DEF = 64;
	// Byte increment carried with each snooper write
	localparam int INC_W_DEF = 8;
	// Packet length in bytes
	localparam int PLEN_W_DEF = 32;

	// Agent-side select, picks which buffer an agent sees
	typedef enum logic [1:0] {
		BUF_NONE = 2'd0,
		BUF_PING = 2'd1,
		BUF_PANG = 2'd2,
		BUF_PONG = 2'd3
	} buf_sel_e;

	// Buffer-side select, picks which agent drives a buffer
	typedef enum logic [1:0] {
		AGT_NONE = 2'd0,
		AGT_SN   = 2'd1,
		AGT_CPU  = 2'd2,
		AGT_FWD  = 2'd3
	} agent_sel_e;

	// Rotation controller states
	typedef enum logic [1:0] {
		CTRL_FILL   = 2'd0,
		CTRL_WAIT   = 2'd1,
		CTRL_ROTATE = 2'd2
	} ctrl_state_e;

endpackage
